/* hdl/cop_pkg.sv */
////////////////////////////////////////////////////////////
// Crypto ISE coprocessor definitions
// Instruction encodings, class and subclass codes, and the
// decoded instruction and host response structs
////////////////////////////////////////////////////////////
package cop_pkg;

    // custom-1
    localparam logic [6:0] COP_MAJOR_OPCODE = 7'b0101011;

    // Function field values within the major opcode
    localparam logic [3:0] FUNC_PADD    = 4'h0;
    localparam logic [3:0] FUNC_PSUB    = 4'h1;
    localparam logic [3:0] FUNC_GPR2XCR = 4'h2;
    localparam logic [3:0] FUNC_XCR2GPR = 4'h3;
    localparam logic [3:0] FUNC_LD_LIU  = 4'h4;
    localparam logic [3:0] FUNC_LD_HIU  = 4'h5;

    typedef enum logic [3:0] {
        ICLASS_NONE         = 4'd0,
        ICLASS_PACKED_ARITH = 4'd1,
        ICLASS_MOVE         = 4'd5,
        ICLASS_BITWISE      = 4'd7
    } cop_iclass_e;

    // Subclass codes, unique across classes
    localparam logic [4:0] SCLASS_PADD    = 5'd0;
    localparam logic [4:0] SCLASS_PSUB    = 5'd1;
    localparam logic [4:0] SCLASS_GPR2XCR = 5'd2;
    localparam logic [4:0] SCLASS_XCR2GPR = 5'd3;
    localparam logic [4:0] SCLASS_LD_LIU  = 5'd5;
    localparam logic [4:0] SCLASS_LD_HIU  = 5'd6;

    // Pack widths, all other codes illegal
    localparam logic [2:0] PW_32 = 3'b000;
    localparam logic [2:0] PW_16 = 3'b001;
    localparam logic [2:0] PW_8  = 3'b010;

    // Register format
    typedef struct packed {
        logic [3:0] func;   // [31:28]
        logic [2:0] pw;     // [27:25]
        logic [3:0] crs2;   // [24:21]
        logic [3:0] crs1;   // [20:17]
        logic [3:0] crd;    // [16:13]
        logic       rsvd;   // [12]
        logic [4:0] gpr;    // GPR rd of xcr2gpr, rs1 name of gpr2xcr
        logic [6:0] opcode;
    } cop_insn_reg_s;

    // Immediate format, crd and func sit where the register format has them
    typedef struct packed {
        logic [3:0]  func;
        logic [10:0] imm_hi;  // imm[15:5]
        logic [3:0]  crd;
        logic [4:0]  imm_lo;  // imm[4:0]
        logic        rsvd;
        logic [6:0]  opcode;
    } cop_insn_imm_s;

    typedef union packed {
        cop_insn_reg_s rtype;
        cop_insn_imm_s itype;
    } cop_insn_u;

    typedef struct packed {
        logic        valid;
        logic        exception;
        cop_iclass_e iclass;
        logic [4:0]  subclass;
        logic [2:0]  pw;
        logic [3:0]  crs1;
        logic [3:0]  crs2;
        logic [3:0]  crs3;
        logic [3:0]  crd;
        logic [4:0]  rd;
        logic [31:0] imm;
    } cop_dec_s;

    typedef struct packed {
        logic        valid;
        logic        exception;
        logic        gpr_we;
        logic [4:0]  rd;
        logic [31:0] value;
    } cop_resp_s;

endpackage

/* hdl/cop_idecode.sv */
////////////////////////////////////////////////////////////
// Coprocessor instruction decoder
// Decodes one instruction word into a registered decoded
// instruction with the illegal instruction flag
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cop_idecode
    import cop_pkg::*;
#(
    parameter bit FEAT_PACKED_EN = 1'b1
) (
    input  logic        g_clk_i,
    input  logic        arst_n_i,
    input  logic        insn_valid_i,
    input  cop_insn_u   insn_enc_i,
    input  logic [31:0] rs1_value_i,
    output cop_dec_s    dec_o,
    output logic [31:0] rs1_value_o
);

    logic     op_match;
    logic     dec_padd;
    logic     dec_psub;
    logic     dec_gpr2xcr;
    logic     dec_xcr2gpr;
    logic     dec_ld_liu;
    logic     dec_ld_hiu;
    logic     class_packed;
    logic     class_move;
    logic     class_bitwise;
    logic     imm_li;
    logic     bad_pw;
    logic     feat_off;
    cop_dec_s dec_d;
    cop_dec_s dec_q;
    logic     valid_q;
    logic     exc_q;

    assign op_match = insn_enc_i.rtype.opcode == COP_MAJOR_OPCODE;

    assign dec_padd    = op_match && (insn_enc_i.rtype.func == FUNC_PADD);
    assign dec_psub    = op_match && (insn_enc_i.rtype.func == FUNC_PSUB);
    assign dec_gpr2xcr = op_match && (insn_enc_i.rtype.func == FUNC_GPR2XCR);
    assign dec_xcr2gpr = op_match && (insn_enc_i.rtype.func == FUNC_XCR2GPR);
    assign dec_ld_liu  = op_match && (insn_enc_i.itype.func == FUNC_LD_LIU);
    assign dec_ld_hiu  = op_match && (insn_enc_i.itype.func == FUNC_LD_HIU);

    assign class_packed  = dec_padd || dec_psub;
    assign class_move    = dec_gpr2xcr || dec_xcr2gpr;
    assign class_bitwise = dec_ld_liu || dec_ld_hiu;
    assign imm_li        = dec_ld_liu || dec_ld_hiu;   // crd doubles as crs3

    assign bad_pw   = class_packed && !(insn_enc_i.rtype.pw inside {PW_32, PW_16, PW_8});
    assign feat_off = class_packed && !FEAT_PACKED_EN;

    always_comb begin
        dec_d           = '0;
        dec_d.valid     = insn_valid_i;
        dec_d.exception = !(class_packed || class_move || class_bitwise) ||
                          bad_pw || feat_off;

        if (class_packed) begin
            dec_d.iclass = ICLASS_PACKED_ARITH;
        end else if (class_move) begin
            dec_d.iclass = ICLASS_MOVE;
        end else if (class_bitwise) begin
            dec_d.iclass = ICLASS_BITWISE;
        end

        dec_d.subclass = {5{dec_padd   }} & SCLASS_PADD    |
                         {5{dec_psub   }} & SCLASS_PSUB    |
                         {5{dec_gpr2xcr}} & SCLASS_GPR2XCR |
                         {5{dec_xcr2gpr}} & SCLASS_XCR2GPR |
                         {5{dec_ld_liu }} & SCLASS_LD_LIU  |
                         {5{dec_ld_hiu }} & SCLASS_LD_HIU  ;

        dec_d.pw   = insn_enc_i.rtype.pw;
        dec_d.crs1 = insn_enc_i.rtype.crs1;
        dec_d.crs2 = insn_enc_i.rtype.crs2;
        dec_d.crd  = insn_enc_i.rtype.crd;
        dec_d.crs3 = imm_li ? insn_enc_i.itype.crd : 4'd0;
        dec_d.rd   = insn_enc_i.rtype.gpr;
        // 16-bit immediate rebuilt from the two split fields
        dec_d.imm  = {32{imm_li}} &
                     {16'b0, insn_enc_i.itype.imm_hi, insn_enc_i.itype.imm_lo};
    end

    always_ff @(posedge g_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            exc_q   <= 1'b0;
        end else begin
            valid_q <= dec_d.valid;
            exc_q   <= dec_d.valid && dec_d.exception;
        end
    end

    // Payload moves only with a live instruction
    always_ff @(posedge g_clk_i) begin
        if (insn_valid_i) begin
            dec_q       <= dec_d;
            rs1_value_o <= rs1_value_i;
        end
    end

    always_comb begin
        dec_o           = dec_q;
        dec_o.valid     = valid_q;
        dec_o.exception = exc_q;
    end

endmodule

/* hdl/cop_regfile.sv */
////////////////////////////////////////////////////////////
// Coprocessor register file
// Sixteen 32-bit registers, three read ports, one write port
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cop_regfile (
    input  logic        g_clk_i,
    input  logic        arst_n_i,
    input  logic [3:0]  rd_addr1_i,
    input  logic [3:0]  rd_addr2_i,
    input  logic [3:0]  rd_addr3_i,
    output logic [31:0] rd_data1_o,
    output logic [31:0] rd_data2_o,
    output logic [31:0] rd_data3_o,
    input  logic        wr_en_i,
    input  logic [3:0]  wr_addr_i,
    input  logic [31:0] wr_data_i
);

    logic [31:0] regs_q  [16];
    logic [3:0]  rd_addr [3];
    logic [31:0] rd_data [3];

    always_ff @(posedge g_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 16; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    assign rd_addr[0] = rd_addr1_i;
    assign rd_addr[1] = rd_addr2_i;
    assign rd_addr[2] = rd_addr3_i;

    // Pending write shows on a read port before the array holds it
    for (genvar p = 0; p < 3; p++) begin : g_rd_port
        assign rd_data[p] = (wr_en_i && (wr_addr_i == rd_addr[p])) ? wr_data_i
                                                                    : regs_q[rd_addr[p]];
    end

    assign rd_data1_o = rd_data[0];
    assign rd_data2_o = rd_data[1];
    assign rd_data3_o = rd_data[2];

endmodule

/* hdl/cop_execute.sv */
////////////////////////////////////////////////////////////
// Coprocessor execute stage
// Packed add/sub, moves and load-immediate, with register
// write back and the registered host response
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cop_execute
    import cop_pkg::*;
(
    input  logic        g_clk_i,
    input  logic        arst_n_i,
    input  cop_dec_s    dec_i,
    input  logic [31:0] rs1_value_i,
    output logic [3:0]  rd_addr1_o,
    output logic [3:0]  rd_addr2_o,
    output logic [3:0]  rd_addr3_o,
    input  logic [31:0] rd_data1_i,
    input  logic [31:0] rd_data2_i,
    input  logic [31:0] rd_data3_i,
    output logic        wr_en_o,
    output logic [3:0]  wr_addr_o,
    output logic [31:0] wr_data_o,
    output cop_resp_s   resp_o
);

    logic        live;
    logic        is_padd;
    logic        is_psub;
    logic        is_gpr2xcr;
    logic        is_xcr2gpr;
    logic        is_ld_liu;
    logic        is_ld_hiu;
    logic        cr_we;
    logic [31:0] lane_msb;
    logic [31:0] padd_res;
    logic [31:0] psub_res;
    logic [31:0] cr_result;
    logic        resp_valid_q;
    logic        resp_exc_q;
    logic        resp_we_q;
    logic [4:0]  resp_rd_q;
    logic [31:0] resp_value_q;

    assign live = dec_i.valid && !dec_i.exception;

    assign is_padd    = (dec_i.iclass == ICLASS_PACKED_ARITH) && (dec_i.subclass == SCLASS_PADD);
    assign is_psub    = (dec_i.iclass == ICLASS_PACKED_ARITH) && (dec_i.subclass == SCLASS_PSUB);
    assign is_gpr2xcr = (dec_i.iclass == ICLASS_MOVE) && (dec_i.subclass == SCLASS_GPR2XCR);
    assign is_xcr2gpr = (dec_i.iclass == ICLASS_MOVE) && (dec_i.subclass == SCLASS_XCR2GPR);
    assign is_ld_liu  = (dec_i.iclass == ICLASS_BITWISE) && (dec_i.subclass == SCLASS_LD_LIU);
    assign is_ld_hiu  = (dec_i.iclass == ICLASS_BITWISE) && (dec_i.subclass == SCLASS_LD_HIU);
    assign cr_we      = is_padd || is_psub || is_gpr2xcr || is_ld_liu || is_ld_hiu;

    assign rd_addr1_o = dec_i.crs1;
    assign rd_addr2_o = dec_i.crs2;
    assign rd_addr3_o = dec_i.crs3;

    // Top bit of every lane
    always_comb begin
        case (dec_i.pw)
            PW_16:   lane_msb = 32'h8000_8000;
            PW_8:    lane_msb = 32'h8080_8080;
            default: lane_msb = 32'h8000_0000;
        endcase
    end

    // Lane MSBs kept out of the wide add, so no carry crosses a lane
    assign padd_res = ((rd_data1_i & ~lane_msb) + (rd_data2_i & ~lane_msb)) ^
                      ((rd_data1_i ^ rd_data2_i) & lane_msb);
    // Same idea for borrows, lane MSB of the minuend forced high
    assign psub_res = ((rd_data1_i | lane_msb) - (rd_data2_i & ~lane_msb)) ^
                      ((rd_data1_i ^ ~rd_data2_i) & lane_msb);

    always_comb begin
        cr_result = rs1_value_i;   // gpr2xcr
        if (is_padd) begin
            cr_result = padd_res;
        end else if (is_psub) begin
            cr_result = psub_res;
        end else if (is_ld_liu) begin
            cr_result = {rd_data3_i[31:16], dec_i.imm[15:0]};
        end else if (is_ld_hiu) begin
            cr_result = {dec_i.imm[15:0], rd_data3_i[15:0]};
        end
    end

    always_ff @(posedge g_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            resp_valid_q <= 1'b0;
            resp_exc_q   <= 1'b0;
            resp_we_q    <= 1'b0;
            wr_en_o      <= 1'b0;
        end else begin
            resp_valid_q <= dec_i.valid;
            resp_exc_q   <= dec_i.valid && dec_i.exception;
            resp_we_q    <= live && is_xcr2gpr;
            wr_en_o      <= live && cr_we;
        end
    end

    always_ff @(posedge g_clk_i) begin
        if (dec_i.valid) begin
            resp_rd_q    <= dec_i.rd;
            resp_value_q <= is_xcr2gpr ? rd_data1_i : cr_result;
            wr_addr_o    <= dec_i.crd;
            wr_data_o    <= cr_result;
        end
    end

    assign resp_o = '{valid:     resp_valid_q,
                      exception: resp_exc_q,
                      gpr_we:    resp_we_q,
                      rd:        resp_rd_q,
                      value:     resp_value_q};

endmodule

/* hdl/cop_top.sv */
////////////////////////////////////////////////////////////
// Crypto ISE coprocessor top level
// Decoder, register file and execute stage
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cop_top
    import cop_pkg::*;
#(
    parameter bit FEAT_PACKED_EN = 1'b1   // Packed arithmetic enable
) (
    input  logic        g_clk_i,
    input  logic        arst_n_i,
    input  logic        insn_valid_i,
    input  cop_insn_u   insn_enc_i,
    input  logic [31:0] rs1_value_i,
    output logic        resp_valid_o,
    output logic        resp_exception_o,
    output logic        resp_gpr_we_o,
    output logic [4:0]  resp_rd_o,
    output logic [31:0] resp_value_o
);

    cop_dec_s    dec;
    logic [31:0] dec_rs1_value;
    logic [3:0]  rf_rd_addr1;
    logic [3:0]  rf_rd_addr2;
    logic [3:0]  rf_rd_addr3;
    logic [31:0] rf_rd_data1;
    logic [31:0] rf_rd_data2;
    logic [31:0] rf_rd_data3;
    logic        rf_wr_en;
    logic [3:0]  rf_wr_addr;
    logic [31:0] rf_wr_data;
    cop_resp_s   resp;

    cop_idecode #(
        .FEAT_PACKED_EN (FEAT_PACKED_EN)
    ) i_cop_idecode (
        .g_clk_i      (g_clk_i),
        .arst_n_i     (arst_n_i),
        .insn_valid_i (insn_valid_i),
        .insn_enc_i   (insn_enc_i),
        .rs1_value_i  (rs1_value_i),
        .dec_o        (dec),
        .rs1_value_o  (dec_rs1_value)
    );

    cop_regfile i_cop_regfile (
        .g_clk_i    (g_clk_i),
        .arst_n_i   (arst_n_i),
        .rd_addr1_i (rf_rd_addr1),
        .rd_addr2_i (rf_rd_addr2),
        .rd_addr3_i (rf_rd_addr3),
        .rd_data1_o (rf_rd_data1),
        .rd_data2_o (rf_rd_data2),
        .rd_data3_o (rf_rd_data3),
        .wr_en_i    (rf_wr_en),
        .wr_addr_i  (rf_wr_addr),
        .wr_data_i  (rf_wr_data)
    );

    cop_execute i_cop_execute (
        .g_clk_i     (g_clk_i),
        .arst_n_i    (arst_n_i),
        .dec_i       (dec),
        .rs1_value_i (dec_rs1_value),
        .rd_addr1_o  (rf_rd_addr1),
        .rd_addr2_o  (rf_rd_addr2),
        .rd_addr3_o  (rf_rd_addr3),
        .rd_data1_i  (rf_rd_data1),
        .rd_data2_i  (rf_rd_data2),
        .rd_data3_i  (rf_rd_data3),
        .wr_en_o     (rf_wr_en),
        .wr_addr_o   (rf_wr_addr),
        .wr_data_o   (rf_wr_data),
        .resp_o      (resp)
    );

    assign resp_valid_o     = resp.valid;
    assign resp_exception_o = resp.exception;
    assign resp_gpr_we_o    = resp.gpr_we;
    assign resp_rd_o        = resp.rd;
    assign resp_value_o     = resp.value;

endmodule

/* sim/cop_top_asserts.sv */
////////////////////////////////////////////////////////////
// Coprocessor protocol assertions
// Response latency, GPR write and register write checks
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cop_top_asserts (
    input logic g_clk_i,
    input logic arst_n_i,
    input logic insn_valid_i,
    input logic resp_valid_i,
    input logic resp_exception_i,
    input logic resp_gpr_we_i,
    input logic rf_wr_en_i
);

    int fail_count = 0;

    // Sampled on the edge two cycles after the instruction
    a_resp_latency : assert property (@(posedge g_clk_i) disable iff (!arst_n_i)
        resp_valid_i == $past(insn_valid_i, 2))
        else begin
            fail_count++;
            $error("resp_valid_o does not follow insn_valid_i by two cycles");
        end

    a_gpr_we_valid : assert property (@(posedge g_clk_i) disable iff (!arst_n_i)
        resp_gpr_we_i |-> resp_valid_i)
        else begin
            fail_count++;
            $error("resp_gpr_we_o high without resp_valid_o");
        end

    // Write enable and exception leave execute on the same edge
    a_no_write_on_exc : assert property (@(posedge g_clk_i) disable iff (!arst_n_i)
        resp_exception_i |-> !rf_wr_en_i)
        else begin
            fail_count++;
            $error("register write together with an exception");
        end

endmodule

bind cop_top cop_top_asserts i_cop_top_asserts (
    .g_clk_i          (g_clk_i),
    .arst_n_i         (arst_n_i),
    .insn_valid_i     (insn_valid_i),
    .resp_valid_i     (resp_valid_o),
    .resp_exception_i (resp_exception_o),
    .resp_gpr_we_i    (resp_gpr_we_o),
    .rf_wr_en_i       (rf_wr_en)
);

/* sim/tb_cop_top.sv */
////////////////////////////////////////////////////////////
// Directed testbench for the crypto ISE coprocessor
// Moves, packed arithmetic, load-immediate, exceptions and
// back-to-back dependent instructions
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_cop_top;
    import cop_pkg::*;

    logic        g_clk;
    logic        arst_n;
    logic        insn_valid;
    cop_insn_u   insn_enc;
    logic [31:0] rs1_value;
    logic        resp_valid;
    logic        resp_exception;
    logic        resp_gpr_we;
    logic [4:0]  resp_rd;
    logic [31:0] resp_value;

    logic [31:0] lfsr_q;
    logic [31:0] cr_model [16];   // Expected coprocessor registers
    cop_resp_s   sample;
    cop_resp_s   resp_q [$];
    time         resp_t_q [$];
    int          checks;
    int          errors;
    int          tests;
    int          failed_tests;
    int          err_mark;

    cop_top #(
        .FEAT_PACKED_EN (1'b1)
    ) i_cop_top (
        .g_clk_i          (g_clk),
        .arst_n_i         (arst_n),
        .insn_valid_i     (insn_valid),
        .insn_enc_i       (insn_enc),
        .rs1_value_i      (rs1_value),
        .resp_valid_o     (resp_valid),
        .resp_exception_o (resp_exception),
        .resp_gpr_we_o    (resp_gpr_we),
        .resp_rd_o        (resp_rd),
        .resp_value_o     (resp_value)
    );

    always #10 g_clk = ~g_clk;

    // Responses collected at the falling edge, where they are stable
    always @(negedge g_clk) begin
        if (arst_n && resp_valid) begin
            sample = '{resp_valid, resp_exception, resp_gpr_we, resp_rd, resp_value};
            resp_q.push_back(sample);
            resp_t_q.push_back($time);
        end
    end

    function automatic logic lfsr_bit();
        logic out;
        out    = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out) begin
            lfsr_q = lfsr_q ^ 32'hA300_0000;   // x^32 + x^30 + x^26 + x^25 + 1
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic cop_insn_u enc_reg(logic [3:0] func, logic [2:0] pw, logic [3:0] crs1,
                                          logic [3:0] crs2, logic [3:0] crd, logic [4:0] gpr);
        cop_insn_u insn;
        insn             = '0;
        insn.rtype.opcode = COP_MAJOR_OPCODE;
        insn.rtype.func  = func;
        insn.rtype.pw    = pw;
        insn.rtype.crs1  = crs1;
        insn.rtype.crs2  = crs2;
        insn.rtype.crd   = crd;
        insn.rtype.gpr   = gpr;
        return insn;
    endfunction

    function automatic cop_insn_u enc_imm(logic [3:0] func, logic [3:0] crd, logic [15:0] imm);
        cop_insn_u insn;
        insn              = '0;
        insn.itype.opcode = COP_MAJOR_OPCODE;
        insn.itype.func   = func;
        insn.itype.crd    = crd;
        insn.itype.imm_hi = imm[15:5];
        insn.itype.imm_lo = imm[4:0];
        return insn;
    endfunction

    // Lane by lane add or subtract, each lane wraps on its own
    function automatic logic [31:0] lane_model(logic [31:0] a, logic [31:0] b,
                                               logic [2:0] pw, bit sub);
        int          w;
        logic [63:0] mask;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] lane;
        logic [31:0] res;
        w    = (pw == PW_8) ? 8 : (pw == PW_16) ? 16 : 32;
        mask = (64'd1 << w) - 64'd1;
        res  = '0;
        for (int i = 0; i < 32 / w; i++) begin
            la   = ({32'b0, a} >> (i * w)) & mask;
            lb   = ({32'b0, b} >> (i * w)) & mask;
            lane = sub ? (la - lb) : (la + lb);
            lane = (lane & mask) << (i * w);
            res  = res | lane[31:0];
        end
        return res;
    endfunction

    function automatic cop_resp_s exp_resp(bit exc, bit gpr_we, logic [4:0] rd,
                                           logic [31:0] value);
        return '{1'b1, exc, gpr_we, rd, value};
    endfunction

    // Value field is compared with check_word
    task automatic check_resp(input cop_resp_s got, input cop_resp_s exp, input string msg);
        checks++;
        if (got.valid !== exp.valid || got.exception !== exp.exception ||
            got.gpr_we !== exp.gpr_we || (exp.gpr_we && got.rd !== exp.rd)) begin
            errors++;
            $display("[FAIL] %0t: %s: got v%0b exc%0b we%0b rd%0d, expected v%0b exc%0b we%0b rd%0d",
                     $time, msg, got.valid, got.exception, got.gpr_we, got.rd,
                     exp.valid, exp.exception, exp.gpr_we, exp.rd);
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s: got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic drive_insn(input cop_insn_u insn, input logic [31:0] rs1);
        @(posedge g_clk);
        #2;
        insn_valid = 1'b1;
        insn_enc   = insn;
        rs1_value  = rs1;
    endtask

    task automatic end_drive();
        @(posedge g_clk);
        #2;
        insn_valid = 1'b0;
    endtask

    task automatic wait_resp(output cop_resp_s r, output time t);
        int n;
        n = 0;
        while (resp_q.size() == 0 && n < 20) begin
            @(negedge g_clk);
            #1;
            n++;
        end
        if (resp_q.size() == 0) begin
            errors++;
            $display("Timeout at %0t: no response within 20 cycles", $time);
            r = '0;
            t = 0;
        end else begin
            r = resp_q.pop_front();
            t = resp_t_q.pop_front();
        end
    endtask

    task automatic run_insn(input cop_insn_u insn, input logic [31:0] rs1,
                            input cop_resp_s exp, input string msg, output cop_resp_s r);
        time t;
        drive_insn(insn, rs1);
        end_drive();
        wait_resp(r, t);
        check_resp(r, exp, msg);
    endtask

    task automatic write_cr(input logic [3:0] idx, input logic [31:0] value);
        cop_resp_s r;
        run_insn(enc_reg(FUNC_GPR2XCR, PW_32, 4'd0, 4'd0, idx, 5'(rand_bits(5))), value,
                 exp_resp(1'b0, 1'b0, 5'd0, 32'd0), "gpr2xcr response", r);
        cr_model[idx] = value;
    endtask

    task automatic read_cr(input logic [3:0] idx);
        cop_resp_s  r;
        logic [4:0] gpr;
        gpr = 5'(rand_bits(5));
        run_insn(enc_reg(FUNC_XCR2GPR, PW_32, idx, 4'd0, 4'd0, gpr), 32'd0,
                 exp_resp(1'b0, 1'b1, gpr, cr_model[idx]), "xcr2gpr response", r);
        check_word(r.value, cr_model[idx], $sformatf("xcr2gpr value of c%0d", idx));
    endtask

    task automatic move_round_trip();
        logic [3:0] idx [6];
        for (int i = 0; i < 6; i++) begin
            idx[i] = 4'(rand_bits(4));
            write_cr(idx[i], rand_bits(32));
        end
        for (int i = 0; i < 6; i++) begin
            read_cr(idx[i]);
        end
    endtask

    task automatic packed_arith();
        logic [2:0]  pws [3];
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rd;
        logic [31:0] expv;
        cop_resp_s   r;
        pws = '{PW_32, PW_16, PW_8};
        for (int p = 0; p < 3; p++) begin
            for (int s = 0; s < 2; s++) begin
                for (int rep = 0; rep < 2; rep++) begin
                    ra = 4'(rand_bits(4));
                    rb = ra + 4'd1 + 4'(rand_bits(3));   // Never equal to ra
                    rd = 4'(rand_bits(4));
                    write_cr(ra, rand_bits(32));
                    write_cr(rb, rand_bits(32));
                    expv = lane_model(cr_model[ra], cr_model[rb], pws[p], s[0]);
                    run_insn(enc_reg(s[0] ? FUNC_PSUB : FUNC_PADD, pws[p], ra, rb, rd, 5'd0),
                             32'd0, exp_resp(1'b0, 1'b0, 5'd0, 32'd0), "packed op response", r);
                    cr_model[rd] = expv;
                    read_cr(rd);
                end
            end
        end
    endtask

    task automatic load_immediate();
        logic [3:0]  k;
        logic [15:0] imm;
        cop_resp_s   r;
        for (int rep = 0; rep < 2; rep++) begin
            k = 4'(rand_bits(4));
            write_cr(k, rand_bits(32));
            imm = 16'(rand_bits(16));
            run_insn(enc_imm(FUNC_LD_LIU, k, imm), 32'd0,
                     exp_resp(1'b0, 1'b0, 5'd0, 32'd0), "ld.liu response", r);
            cr_model[k] = {cr_model[k][31:16], imm};
            read_cr(k);
            imm = 16'(rand_bits(16));
            run_insn(enc_imm(FUNC_LD_HIU, k, imm), 32'd0,
                     exp_resp(1'b0, 1'b0, 5'd0, 32'd0), "ld.hiu response", r);
            cr_model[k] = {imm, cr_model[k][15:0]};
            read_cr(k);
        end
    endtask

    task automatic exception_cases();
        logic [3:0] k;
        cop_insn_u  insn;
        cop_resp_s  r;
        k = 4'(rand_bits(4));
        write_cr(k, rand_bits(32));
        insn = enc_reg(FUNC_GPR2XCR, PW_32, 4'd0, 4'd0, k, 5'd0);
        insn.rtype.opcode = 7'b0001011;   // custom-0
        run_insn(insn, rand_bits(32), exp_resp(1'b1, 1'b0, 5'd0, 32'd0), "wrong opcode", r);
        read_cr(k);
        run_insn(enc_reg(4'hF, PW_32, k, k, k, 5'd0), 32'd0,
                 exp_resp(1'b1, 1'b0, 5'd0, 32'd0), "unknown function", r);
        read_cr(k);
        run_insn(enc_reg(FUNC_PADD, 3'b111, k, k, k, 5'd0), 32'd0,
                 exp_resp(1'b1, 1'b0, 5'd0, 32'd0), "illegal pack width", r);
        read_cr(k);
    endtask

    // Each instruction reads the register written just before it
    task automatic back_to_back();
        logic [3:0]  k;
        logic [3:0]  j;
        logic [4:0]  gpr;
        logic [31:0] x;
        cop_resp_s   rs [3];
        time         ts [3];
        k   = 4'(rand_bits(4));
        j   = k + 4'd1 + 4'(rand_bits(3));
        gpr = 5'(rand_bits(5));
        x   = rand_bits(32);
        write_cr(j, rand_bits(32));
        drive_insn(enc_reg(FUNC_GPR2XCR, PW_32, 4'd0, 4'd0, k, 5'd0), x);
        drive_insn(enc_reg(FUNC_PADD, PW_16, k, j, k, 5'd0), 32'd0);
        drive_insn(enc_reg(FUNC_XCR2GPR, PW_32, k, 4'd0, 4'd0, gpr), 32'd0);
        end_drive();
        cr_model[k] = lane_model(x, cr_model[j], PW_16, 1'b0);
        for (int i = 0; i < 3; i++) begin
            wait_resp(rs[i], ts[i]);
        end
        check_resp(rs[0], exp_resp(1'b0, 1'b0, 5'd0, 32'd0), "first of chain");
        check_resp(rs[1], exp_resp(1'b0, 1'b0, 5'd0, 32'd0), "second of chain");
        check_resp(rs[2], exp_resp(1'b0, 1'b1, gpr, cr_model[k]), "third of chain");
        check_word(rs[2].value, cr_model[k], "bypassed result");
        check_word(32'(ts[1] - ts[0]), 32'd20, "spacing of responses 1 and 2");
        check_word(32'(ts[2] - ts[1]), 32'd20, "spacing of responses 2 and 3");
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors != err_before) begin
            failed_tests++;
            $display("Test %s: failed with %0d errors", name, errors - err_before);
        end else begin
            $display("Test %s: passed", name);
        end
    endtask

    initial begin
        g_clk        = 1'b0;
        arst_n       = 1'b0;
        insn_valid   = 1'b0;
        insn_enc     = '0;
        rs1_value    = '0;
        lfsr_q       = 32'd91903;
        checks       = 0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        for (int i = 0; i < 16; i++) begin
            cr_model[i] = '0;
        end
        repeat (16) @(posedge g_clk);
        #2;
        arst_n = 1'b1;

        err_mark = errors;
        move_round_trip();
        report_test("move round trip", err_mark);
        err_mark = errors;
        packed_arith();
        report_test("packed arithmetic", err_mark);
        err_mark = errors;
        load_immediate();
        report_test("load immediate", err_mark);
        err_mark = errors;
        exception_cases();
        report_test("exceptions", err_mark);
        err_mark = errors;
        back_to_back();
        report_test("back to back", err_mark);

        $display("Tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, failed_tests, checks, errors, i_cop_top.i_cop_top_asserts.fail_count);
        if (errors == 0 && i_cop_top.i_cop_top_asserts.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
hdl/cop_pkg.sv
hdl/cop_idecode.sv
hdl/cop_regfile.sv
hdl/cop_execute.sv
hdl/cop_top.sv
sim/cop_top_asserts.sv
sim/tb_cop_top.sv
